// ==== sources.f ====
hw/frame_pkg.sv
hw/spi_peripheral.sv
hw/spi_register.sv
hw/display_timing.sv
hw/graphics.sv
hw/top.sv
tests/top_tb.sv

// ==== tests/top_tb.sv ====
// Testbench for the SPI controlled display subsystem with chip ID, fill colour and frame counter
`timescale 1ns/100ps
`default_nettype none

module top_tb;
    import frame_pkg::*;

    localparam int H_ACTIVE = 16;
    localparam int H_SYNC = 4;
    localparam int H_TOTAL = 24;
    localparam int V_ACTIVE = 8;
    localparam int V_SYNC = 2;
    localparam int V_TOTAL = 12;
    localparam int HALF_PERIOD = 6;             // SPI half-period in clocks
    localparam int FRAME_TIMEOUT = 3 * H_TOTAL * V_TOTAL;
    localparam int COMMAND_OFFSET = 150;        // Lands both operands in the same frame
    localparam int READ_OFFSET = 20;            // Snapshot well before vsync

    logic clock;
    logic rst;
    logic spi_select;
    logic spi_clock;
    logic spi_data_in;
    logic spi_data_out;
    logic display_hsync;
    logic display_vsync;
    y_t display_y;
    c_t display_cb;
    c_t display_cr;

    byte_t tx_buf [0:3];
    byte_t rx_buf [0:3];
    logic [15:0] lfsr_state;

    // Display monitor
    logic hsync_prev;
    logic vsync_prev;
    logic hsync_seen;
    logic vsync_seen;
    logic locked;
    logic frame_start_seen;
    logic in_active;
    int col_reg;
    int row_reg;
    int frame_reg;
    int vsync_rises;
    int col;
    int row;
    int frame_id;

    // Expected picture as {y, cb, cr}
    logic [9:0] shown_before;
    logic [9:0] shown_after;
    logic [9:0] pixel_expected;
    logic [9:0] model_colour;
    logic model_enable;
    int switch_frame;

    logic pixel_check_on;
    logic sync_check_on;
    logic response_check;
    byte_t response_expected;
    byte_t response_actual;
    string test_name;
    int test_errors;
    int tests_run;
    int tests_failed;
    int aligned_frame;
    int aligned_vsync;

    top #(
        .H_ACTIVE(H_ACTIVE),
        .H_SYNC(H_SYNC),
        .H_TOTAL(H_TOTAL),
        .V_ACTIVE(V_ACTIVE),
        .V_SYNC(V_SYNC),
        .V_TOTAL(V_TOTAL)
    ) i_dut (
        .clock(clock),
        .rst(rst),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out),
        .display_hsync(display_hsync),
        .display_vsync(display_vsync),
        .display_y(display_y),
        .display_cb(display_cb),
        .display_cr(display_cr)
    );

    always #2 clock = ~clock;

    // Position of the sample now at the ports, rebuilt from the sync edges
    always_comb begin
        locked = hsync_seen && vsync_seen;
        col = (display_hsync && !hsync_prev) ? H_ACTIVE : col_reg;
        row = (display_vsync && !vsync_prev) ? V_ACTIVE : row_reg;
        frame_start_seen = locked && (col == 0) && (row == 0);
        frame_id = frame_start_seen ? frame_reg + 1 : frame_reg;
        in_active = locked && (col < H_ACTIVE) && (row < V_ACTIVE);
        if (!in_active) begin
            pixel_expected = '0;
        end else if (frame_id < switch_frame) begin
            pixel_expected = shown_before;
        end else begin
            pixel_expected = shown_after;
        end
    end

    always @(posedge clock) begin
        if (rst) begin
            hsync_prev <= 1'b0;
            vsync_prev <= 1'b0;
            hsync_seen <= 1'b0;
            vsync_seen <= 1'b0;
            col_reg <= 0;
            row_reg <= 0;
            frame_reg <= 0;
            vsync_rises <= 0;
        end else begin
            hsync_prev <= display_hsync;
            vsync_prev <= display_vsync;
            if (display_hsync && !hsync_prev) begin
                hsync_seen <= 1'b1;
            end
            if (display_vsync && !vsync_prev) begin
                vsync_seen <= 1'b1;
                vsync_rises <= vsync_rises + 1;
            end
            col_reg <= (col == H_TOTAL - 1) ? 0 : col + 1;
            if (col == H_TOTAL - 1) begin
                row_reg <= (row == V_TOTAL - 1) ? 0 : row + 1;
            end else begin
                row_reg <= row;
            end
            if (frame_start_seen) begin
                frame_reg <= frame_reg + 1;
            end
        end
    end

    response_value: assert property (@(posedge clock) disable iff (rst)
        response_check |-> response_actual == response_expected)
        else begin
            test_errors++;
            $display("Error %s: expected %h, actual %h", test_name, response_expected,
                     response_actual);
        end

    pixel_value: assert property (@(posedge clock) disable iff (rst)
        pixel_check_on |-> {display_y, display_cb, display_cr} == pixel_expected)
        else begin
            test_errors++;
            $display("Error %s: expected pixel %h, actual %h", test_name,
                     $sampled(pixel_expected), $sampled({display_y, display_cb, display_cr}));
        end

    hsync_width: assert property (@(posedge clock) disable iff (rst)
        sync_check_on && $rose(display_hsync) |-> ##H_SYNC $fell(display_hsync))
        else begin
            test_errors++;
            $display("%s: hsync pulse is not %0d clocks wide", test_name, H_SYNC);
        end

    hsync_period: assert property (@(posedge clock) disable iff (rst)
        sync_check_on && $rose(display_hsync) |-> ##H_TOTAL $rose(display_hsync))
        else begin
            test_errors++;
            $display("%s: hsync edges are not %0d clocks apart", test_name, H_TOTAL);
        end

    vsync_width: assert property (@(posedge clock) disable iff (rst)
        sync_check_on && $rose(display_vsync) |-> ##(V_SYNC * H_TOTAL) $fell(display_vsync))
        else begin
            test_errors++;
            $display("%s: vsync pulse is not %0d lines long", test_name, V_SYNC);
        end

    vsync_period: assert property (@(posedge clock) disable iff (rst)
        sync_check_on && $rose(display_vsync) |-> ##(H_TOTAL * V_TOTAL) $rose(display_vsync))
        else begin
            test_errors++;
            $display("%s: vsync edges are not one frame apart", test_name);
        end

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic draw_bits(input int count, output logic [9:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value = {value[8:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic give_up(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Checks failed");
        $finish;
    endtask

    // Mode 0 transfer, host samples MISO on its own rising edges
    task automatic spi_transfer(input int length);
        int b;
        int i;
        @(posedge clock);
        spi_select <= 1'b0;
        for (b = 0; b < length; b++) begin
            for (i = 7; i >= 0; i--) begin
                @(posedge clock);
                spi_clock <= 1'b0;
                spi_data_in <= tx_buf[b][i];
                repeat (HALF_PERIOD - 1) @(posedge clock);
                @(posedge clock);
                rx_buf[b][i] = spi_data_out;
                spi_clock <= 1'b1;
                repeat (HALF_PERIOD - 1) @(posedge clock);
            end
        end
        @(posedge clock);
        spi_clock <= 1'b0;
        spi_data_in <= 1'b0;
        repeat (HALF_PERIOD - 1) @(posedge clock);
        @(posedge clock);
        spi_select <= 1'b1;
        repeat (HALF_PERIOD) @(posedge clock);
    endtask

    task automatic wait_frame_start;
        int waited;
        waited = 0;
        @(posedge clock);
        while (!frame_start_seen) begin
            waited++;
            if (waited > FRAME_TIMEOUT) begin
                give_up("a frame start on the display outputs");
            end
            @(posedge clock);
        end
        aligned_frame = frame_id;
        aligned_vsync = vsync_rises;
    endtask

    task automatic wait_vsync_rises(input int count);
        int waited;
        int target;
        waited = 0;
        target = vsync_rises + count;
        while (vsync_rises < target) begin
            waited++;
            if (waited > count * FRAME_TIMEOUT) begin
                give_up("vsync rising edges");
            end
            @(posedge clock);
        end
    endtask

    // New settings show from the second frame start after alignment
    task automatic command_mid_frame(input int length, input logic [9:0] colour,
                                     input logic enable);
        wait_frame_start();
        shown_before = shown_after;
        switch_frame = aligned_frame + 2;
        model_colour = colour;
        model_enable = enable;
        shown_after = enable ? colour : '0;
        repeat (COMMAND_OFFSET) @(posedge clock);
        spi_transfer(length);
    endtask

    task automatic check_response(input byte_t expected, input byte_t actual);
        @(posedge clock);
        response_expected <= expected;
        response_actual <= actual;
        response_check <= 1'b1;
        @(posedge clock);
        response_check <= 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test;
        repeat (2) @(posedge clock);            // Let pending action blocks run
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: passed", test_name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic load_colour_command(input logic [9:0] colour);
        tx_buf[0] = OPCODE_SET_COLOUR;
        tx_buf[1] = {4'b0, colour[9:6]};
        tx_buf[2] = {2'b0, colour[5:0]};
    endtask

    initial begin
        logic [9:0] colour_a;
        logic [9:0] colour_b;
        logic [9:0] gap;
        byte_t count_1;
        int vsync_1;

        clock = 1'b0;
        rst = 1'b1;
        spi_select = 1'b1;
        spi_clock = 1'b0;
        spi_data_in = 1'b0;
        lfsr_state = 16'd34997;
        shown_before = '0;
        shown_after = '0;
        model_colour = '0;
        model_enable = 1'b0;
        switch_frame = 0;
        pixel_check_on = 1'b0;
        sync_check_on = 1'b0;
        response_check = 1'b0;
        response_expected = '0;
        response_actual = '0;
        tests_run = 0;
        tests_failed = 0;
        repeat (5) @(posedge clock);
        rst <= 1'b0;

        begin_test("chip id");
        tx_buf[0] = OPCODE_CHIP_ID;
        tx_buf[1] = 8'h00;
        spi_transfer(2);
        check_response(8'h81, rx_buf[1]);
        tx_buf[0] = 8'h55;                      // Unclaimed opcode
        spi_transfer(2);
        check_response(8'h00, rx_buf[1]);
        end_test();

        begin_test("sync timing");
        sync_check_on = 1'b1;
        wait_vsync_rises(3);
        sync_check_on = 1'b0;
        wait_vsync_rises(1);
        end_test();

        begin_test("fill colour");
        draw_bits(10, colour_a);
        pixel_check_on = 1'b1;
        load_colour_command(colour_a);
        command_mid_frame(3, colour_a, model_enable);
        tx_buf[0] = OPCODE_SET_ENABLE;
        tx_buf[1] = 8'h01;
        command_mid_frame(2, model_colour, 1'b1);
        repeat (3) wait_frame_start();
        end_test();

        begin_test("frame boundary");
        draw_bits(10, colour_b);
        if (colour_b == colour_a) begin
            colour_b[9:6] = ~colour_b[9:6];
        end
        load_colour_command(colour_b);
        command_mid_frame(3, colour_b, model_enable);
        repeat (3) wait_frame_start();
        end_test();

        begin_test("disable");
        tx_buf[0] = OPCODE_SET_ENABLE;
        tx_buf[1] = 8'h00;
        command_mid_frame(2, model_colour, 1'b0);
        repeat (3) wait_frame_start();
        end_test();

        begin_test("frame counter");
        tx_buf[0] = OPCODE_FRAME_COUNT;
        tx_buf[1] = 8'h00;
        wait_frame_start();
        vsync_1 = aligned_vsync;
        repeat (READ_OFFSET) @(posedge clock);
        spi_transfer(2);
        count_1 = rx_buf[1];
        draw_bits(2, gap);
        repeat (gap + 1) wait_frame_start();
        wait_frame_start();
        repeat (READ_OFFSET) @(posedge clock);
        spi_transfer(2);
        check_response(count_1 + byte_t'(aligned_vsync - vsync_1), rx_buf[1]);
        end_test();

        $display("%0d tests run, %0d passed, %0d failed", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/top.sv ====
// Top level joining the SPI peripheral, chip ID register and graphics
`timescale 1ns/100ps
`default_nettype none

module top #(
    parameter int H_ACTIVE = 640,
    parameter int H_SYNC = 96,
    parameter int H_TOTAL = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_SYNC = 2,
    parameter int V_TOTAL = 525
) (
    input logic clock,
    input logic rst,

    input logic spi_select,
    input logic spi_clock,
    input logic spi_data_in,
    output logic spi_data_out,

    output logic display_hsync,
    output logic display_vsync,
    output frame_pkg::y_t display_y,
    output frame_pkg::c_t display_cb,
    output frame_pkg::c_t display_cr
);
    import frame_pkg::*;

    // Byte stream from the peripheral
    byte_t opcode;
    logic opcode_valid;
    byte_t operand;
    logic operand_valid;
    byte_t operand_count;

    byte_t response_1;
    logic response_1_valid;
    byte_t response_2;
    logic response_2_valid;

    spi_peripheral spi_peripheral (
        .clock(clock),
        .rst(rst),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out),
        .opcode(opcode),
        .opcode_valid(opcode_valid),
        .operand(operand),
        .operand_valid(operand_valid),
        .operand_count(operand_count),
        .response_1(response_1),
        .response_1_valid(response_1_valid),
        .response_2(response_2),
        .response_2_valid(response_2_valid)
    );

    spi_register #(
        .REGISTER_ADDRESS(OPCODE_CHIP_ID),
        .REGISTER_VALUE(CHIP_ID)
    ) chip_id (
        .clock(clock),
        .rst(rst),
        .opcode(opcode),
        .opcode_valid(opcode_valid),
        .response(response_1),
        .response_valid(response_1_valid)
    );

    graphics #(
        .H_ACTIVE(H_ACTIVE),
        .H_SYNC(H_SYNC),
        .H_TOTAL(H_TOTAL),
        .V_ACTIVE(V_ACTIVE),
        .V_SYNC(V_SYNC),
        .V_TOTAL(V_TOTAL)
    ) graphics (
        .clock(clock),
        .rst(rst),
        .opcode(opcode),
        .opcode_valid(opcode_valid),
        .operand(operand),
        .operand_valid(operand_valid),
        .operand_count(operand_count),
        .response(response_2),
        .response_valid(response_2_valid),
        .display_hsync(display_hsync),
        .display_vsync(display_vsync),
        .display_y(display_y),
        .display_cb(display_cb),
        .display_cr(display_cr)
    );

endmodule

`default_nettype wire

// ==== hw/graphics.sv ====
// Graphics block with fill colour, display enable and frame counter over SPI
`timescale 1ns/100ps
`default_nettype none

module graphics #(
    parameter int H_ACTIVE = 640,
    parameter int H_SYNC = 96,
    parameter int H_TOTAL = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_SYNC = 2,
    parameter int V_TOTAL = 525
) (
    input logic clock,
    input logic rst,

    input frame_pkg::byte_t opcode,
    input logic opcode_valid,
    input frame_pkg::byte_t operand,
    input logic operand_valid,
    input frame_pkg::byte_t operand_count,
    output frame_pkg::byte_t response,
    output logic response_valid,

    output logic display_hsync,
    output logic display_vsync,
    output frame_pkg::y_t display_y,
    output frame_pkg::c_t display_cb,
    output frame_pkg::c_t display_cr
);
    import frame_pkg::*;

    logic hsync;
    logic vsync;
    logic active;
    logic frame_start;

    y_t pending_y, live_y, colour_y;
    c_t pending_cb, live_cb, colour_cb;
    c_t pending_cr, live_cr, colour_cr;
    logic pending_enable, live_enable, colour_enable;

    byte_t frame_count;
    byte_t count_snapshot;
    logic opcode_valid_prev;
    logic count_match;

    display_timing #(
        .H_ACTIVE(H_ACTIVE),
        .H_SYNC(H_SYNC),
        .H_TOTAL(H_TOTAL),
        .V_ACTIVE(V_ACTIVE),
        .V_SYNC(V_SYNC),
        .V_TOTAL(V_TOTAL)
    ) display_timing (
        .clock(clock),
        .rst(rst),
        .hsync(hsync),
        .vsync(vsync),
        .active(active),
        .frame_start(frame_start)
    );

    // Commands land in pending registers
    always_ff @(posedge clock) begin
        if (rst) begin
            pending_y <= '0;
            pending_cb <= '0;
            pending_cr <= '0;
            pending_enable <= 1'b0;
        end else if (opcode_valid && operand_valid) begin
            case (opcode)
                OPCODE_SET_COLOUR: begin
                    if (operand_count == 8'd0) begin
                        pending_y <= operand[3:0];
                    end else if (operand_count == 8'd1) begin
                        pending_cb <= operand[5:3];
                        pending_cr <= operand[2:0];
                    end
                end
                OPCODE_SET_ENABLE: begin
                    if (operand_count == 8'd0) begin
                        pending_enable <= operand[0];
                    end
                end
                default: ;
            endcase
        end
    end

    // Frame boundary swaps in the pending settings
    always_ff @(posedge clock) begin
        if (rst) begin
            live_y <= '0;
            live_cb <= '0;
            live_cr <= '0;
            live_enable <= 1'b0;
            frame_count <= '0;
        end else if (frame_start) begin
            live_y <= pending_y;
            live_cb <= pending_cb;
            live_cr <= pending_cr;
            live_enable <= pending_enable;
            frame_count <= frame_count + 8'd1;
        end
    end

    // First pixel of a frame already uses the new settings
    assign colour_y = frame_start ? pending_y : live_y;
    assign colour_cb = frame_start ? pending_cb : live_cb;
    assign colour_cr = frame_start ? pending_cr : live_cr;
    assign colour_enable = frame_start ? pending_enable : live_enable;

    always_ff @(posedge clock) begin
        if (rst) begin
            display_hsync <= 1'b0;
            display_vsync <= 1'b0;
            display_y <= '0;
            display_cb <= '0;
            display_cr <= '0;
        end else begin
            display_hsync <= hsync;
            display_vsync <= vsync;
            display_y <= (active && colour_enable) ? colour_y : '0;
            display_cb <= (active && colour_enable) ? colour_cb : '0;
            display_cr <= (active && colour_enable) ? colour_cr : '0;
        end
    end

    // Frame counter read
    always_ff @(posedge clock) begin
        if (rst) begin
            opcode_valid_prev <= 1'b0;
            count_match <= 1'b0;
        end else begin
            opcode_valid_prev <= opcode_valid;
            count_match <= opcode_valid && (opcode == OPCODE_FRAME_COUNT);
        end
    end

    always_ff @(posedge clock) begin
        if (opcode_valid && !opcode_valid_prev) begin
            count_snapshot <= frame_count;      // Held for the whole transaction
        end
    end

    assign response = count_snapshot;
    assign response_valid = count_match & opcode_valid;

endmodule

`default_nettype wire

// ==== hw/display_timing.sv ====
// Display timing generator for hsync, vsync, active area and frame start
`timescale 1ns/100ps
`default_nettype none

module display_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_SYNC = 96,
    parameter int H_TOTAL = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_SYNC = 2,
    parameter int V_TOTAL = 525
) (
    input logic clock,
    input logic rst,

    output logic hsync,
    output logic vsync,
    output logic active,
    output logic frame_start
);

    // One spare count so the sync end values always fit
    localparam int H_BITS = $clog2(H_TOTAL + 1);
    localparam int V_BITS = $clog2(V_TOTAL + 1);

    logic [H_BITS-1:0] h_count;
    logic [V_BITS-1:0] v_count;

    always_ff @(posedge clock) begin
        if (rst) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == H_BITS'(H_TOTAL - 1)) begin
            h_count <= '0;                      // End of line
            if (v_count == V_BITS'(V_TOTAL - 1)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + V_BITS'(1);
            end
        end else begin
            h_count <= h_count + H_BITS'(1);
        end
    end

    assign active = (h_count < H_BITS'(H_ACTIVE)) && (v_count < V_BITS'(V_ACTIVE));

    // Sync pulses follow the active area directly
    assign hsync = (h_count >= H_BITS'(H_ACTIVE)) &&
                   (h_count < H_BITS'(H_ACTIVE + H_SYNC));
    assign vsync = (v_count >= V_BITS'(V_ACTIVE)) &&
                   (v_count < V_BITS'(V_ACTIVE + V_SYNC));

    assign frame_start = (h_count == '0) && (v_count == '0);

    no_sync_in_active: assert property (@(posedge clock) disable iff (rst)
        hsync |-> !active);

    single_frame_start: assert property (@(posedge clock) disable iff (rst)
        frame_start |=> !frame_start);

endmodule

`default_nettype wire

// ==== hw/spi_register.sv ====
// Read-only register returning a fixed byte for one opcode
`timescale 1ns/100ps
`default_nettype none

module spi_register #(
    parameter frame_pkg::byte_t REGISTER_ADDRESS = 8'h00,
    parameter frame_pkg::byte_t REGISTER_VALUE = 8'h00
) (
    input logic clock,
    input logic rst,

    input frame_pkg::byte_t opcode,
    input logic opcode_valid,
    output frame_pkg::byte_t response,
    output logic response_valid
);

    logic address_match;

    always_ff @(posedge clock) begin
        if (rst) begin
            address_match <= 1'b0;
        end else begin
            address_match <= opcode_valid && (opcode == REGISTER_ADDRESS);
        end
    end

    // Drops together with opcode_valid at the end of the transaction
    assign response_valid = address_match & opcode_valid;
    assign response = REGISTER_VALUE;

    valid_within_opcode: assert property (@(posedge clock) disable iff (rst)
        response_valid |-> opcode_valid);

endmodule

`default_nettype wire

// ==== hw/spi_peripheral.sv ====
// SPI mode 0 peripheral that frames opcode and operand bytes and returns a response
`timescale 1ns/100ps
`default_nettype none

module spi_peripheral (
    input logic clock,
    input logic rst,

    input logic spi_select,
    input logic spi_clock,
    input logic spi_data_in,
    output logic spi_data_out,

    output frame_pkg::byte_t opcode,
    output logic opcode_valid,
    output frame_pkg::byte_t operand,
    output logic operand_valid,
    output frame_pkg::byte_t operand_count,

    input frame_pkg::byte_t response_1,
    input logic response_1_valid,
    input frame_pkg::byte_t response_2,
    input logic response_2_valid
);
    import frame_pkg::*;

    logic [1:0] select_sync;
    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic sclk_prev;

    logic selected;
    logic sclk_rise;
    logic sclk_fall;

    logic [2:0] bit_count;                      // Bit within current byte
    byte_t byte_count;                          // Bytes completed this transaction
    logic [6:0] shift_in;
    byte_t rx_byte;
    byte_t shift_out;
    byte_t response;

    // Two-flop synchronizers on the control pins
    always_ff @(posedge clock) begin
        if (rst) begin
            select_sync <= 2'b11;
            sclk_sync <= 2'b00;
            sclk_prev <= 1'b0;
        end else begin
            select_sync <= {select_sync[0], spi_select};
            sclk_sync <= {sclk_sync[0], spi_clock};
            sclk_prev <= sclk_sync[1];
        end
    end

    always_ff @(posedge clock) begin
        mosi_sync <= {mosi_sync[0], spi_data_in};
    end

    assign selected = ~select_sync[1];          // Select is active low
    assign sclk_rise = selected & sclk_sync[1] & ~sclk_prev;
    assign sclk_fall = selected & ~sclk_sync[1] & sclk_prev;
    assign rx_byte = {shift_in, mosi_sync[1]};

    // Byte framing
    always_ff @(posedge clock) begin
        if (rst || !selected) begin
            bit_count <= '0;
            byte_count <= '0;
            opcode_valid <= 1'b0;
            operand_valid <= 1'b0;
        end else begin
            operand_valid <= 1'b0;
            if (sclk_rise) begin
                bit_count <= bit_count + 3'd1;
                if (bit_count == 3'd7) begin
                    if (byte_count == 8'd0) begin
                        opcode_valid <= 1'b1;
                    end else begin
                        operand_valid <= 1'b1;
                    end
                    if (byte_count != 8'hFF) begin
                        byte_count <= byte_count + 8'd1;   // Saturates on long bursts
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (sclk_rise) begin
            shift_in <= rx_byte[6:0];
            if (bit_count == 3'd7 && byte_count == 8'd0) begin
                opcode <= rx_byte;
            end
            if (bit_count == 3'd7 && byte_count != 8'd0) begin
                operand <= rx_byte;
                operand_count <= byte_count - 8'd1;
            end
        end
    end

    // Whichever responder owns the opcode
    always_comb begin
        if (response_1_valid) begin
            response = response_1;
        end else if (response_2_valid) begin
            response = response_2;
        end else begin
            response = '0;
        end
    end

    // Response goes out during the second byte, MSB first
    always_ff @(posedge clock) begin
        if (rst || !selected) begin
            shift_out <= '0;
        end else if (sclk_fall) begin
            if (bit_count == 3'd0 && byte_count == 8'd1) begin
                shift_out <= response;
            end else begin
                shift_out <= {shift_out[6:0], 1'b0};
            end
        end
    end

    assign spi_data_out = shift_out[7];

    operand_after_opcode: assert property (@(posedge clock) disable iff (rst)
        operand_valid |-> opcode_valid);

    single_responder: assert property (@(posedge clock) disable iff (rst)
        $onehot0({response_1_valid, response_2_valid}));

endmodule

`default_nettype wire

// ==== hw/frame_pkg.sv ====
// Shared opcodes, chip ID value and pixel sample types for the frame subsystem
`default_nettype none

package frame_pkg;

    // One SPI byte
    typedef logic [7:0] byte_t;

    // Pixel samples
    typedef logic [3:0] y_t;
    typedef logic [2:0] c_t;                    // Used for both Cb and Cr

    // Chip identification
    localparam byte_t OPCODE_CHIP_ID = 8'hDB;
    localparam byte_t CHIP_ID = 8'h81;

    // Fill colour
    // Operand 0 holds Y in bits 3..0
    // Operand 1 holds Cb in bits 5..3 and Cr in bits 2..0
    localparam byte_t OPCODE_SET_COLOUR = 8'h10;

    // Display enable in bit 0 of operand 0
    localparam byte_t OPCODE_SET_ENABLE = 8'h11;

    // Low byte of the frame counter
    localparam byte_t OPCODE_FRAME_COUNT = 8'h12;

endpackage

`default_nettype wire
